//--- include/fb_params.svh
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

////////////////////////////////////////////////////////////
// Active frame

`define FB_W            16
`define FB_H            12
`define FB_PIXELS       (`FB_W * `FB_H)
`define FB_ADDR_W       8
`define FB_X_W          4
`define FB_Y_W          4
`define PIX_W           2

////////////////////////////////////////////////////////////
// Scan timing, counted in clocks and lines

`define H_TOTAL         24
`define V_TOTAL         16
`define H_CNT_W         5
`define V_CNT_W         4
`define H_SYNC_START    18
`define H_SYNC_LEN      2
`define V_SYNC_START    13
`define V_SYNC_LEN      1

////////////////////////////////////////////////////////////
// Serial link

`define CLKS_PER_BIT    8
`define BAUD_CNT_W      4

`endif

//--- design/fb_pkg.sv
`include "fb_params.svh"

package fb_pkg;

   // Gray level, also used for each colour channel
   typedef logic [`PIX_W-1:0] pixel_t;

   // Byte handed from receiver to writer
   typedef struct packed {
      logic [7:0] data;
   } rx_byte_t;

   // Frame store write port
   typedef struct packed {
      logic                  en;
      logic [`FB_ADDR_W-1:0] addr;
      pixel_t                data;
   } wr_port_t;

   // Current scan position
   typedef struct packed {
      logic [`FB_X_W-1:0] x;
      logic [`FB_Y_W-1:0] y;
      logic               active;
   } scan_pos_t;

   // Video output bundle, syncs active low
   typedef struct packed {
      logic   hs;
      logic   vs;
      logic   de;
      pixel_t r;
      pixel_t g;
      pixel_t b;
   } video_out_t;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/100ps
`include "fb_params.svh"

module uart_rx import fb_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_rx,
   output logic     o_req,
   input  logic     i_ack,
   output rx_byte_t o_byte
);

   localparam int CNT_W = `BAUD_CNT_W;
   localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`CLKS_PER_BIT / 2 - 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t        state;
   logic [1:0]       rx_sync;
   logic             rx_s;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   logic [7:0]       shreg;
   logic             bit_end;
   logic             take_bit;
   logic             byte_ok;

   // Line idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 2'b11;
      end else begin
         rx_sync <= {rx_sync[0], i_rx};
      end
   end

   assign rx_s     = rx_sync[1];
   assign bit_end  = (cnt == CNT_LAST);
   assign take_bit = (state == RX_DATA) && bit_end;
   // Stop bit good and no handshake still open
   assign byte_ok  = (state == RX_STOP) && bit_end && rx_s && !o_req && !i_ack;

   ////////////////////////////////////////////////////////////
   // Bit framing

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_s) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               // Recheck at mid start bit to reject glitches
               if (cnt == CNT_HALF) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rx_s ? RX_IDLE : RX_DATA;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= RX_STOP;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: begin
               if (bit_end) begin
                  state <= RX_IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Byte output, four-phase handshake

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_req <= 1'b0;
      end else if (byte_ok) begin
         o_req <= 1'b1;
      end else if (o_req && i_ack) begin
         o_req <= 1'b0;
      end
   end

   // LSB first
   always_ff @(posedge i_clk) begin
      if (take_bit) begin
         shreg <= {rx_s, shreg[7:1]};
      end
      if (byte_ok) begin
         o_byte.data <= shreg;
      end
   end

endmodule

//--- design/pixel_writer.sv
`timescale 1ns/100ps
`include "fb_params.svh"

module pixel_writer import fb_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_req,
   output logic     o_ack,
   input  rx_byte_t i_byte,
   output wr_port_t o_wr
);

   localparam int ADDR_W = `FB_ADDR_W;
   localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(`FB_PIXELS - 1);

   typedef enum logic [1:0] {WR_IDLE, WR_WRITE, WR_RELEASE} wr_state_t;

   wr_state_t         state;
   logic [1:0]        slot;
   logic [ADDR_W-1:0] addr;
   logic [5:0]        pix_bits;
   logic              accept;

   assign accept = (state == WR_IDLE) && i_req && !o_ack;

   ////////////////////////////////////////////////////////////
   // Handshake

   // Ack drops one clock after req goes low
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_ack <= 1'b0;
      end else if (accept) begin
         o_ack <= 1'b1;
      end else if (!i_req) begin
         o_ack <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Write sequencing and address

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= WR_IDLE;
         slot  <= '0;
         addr  <= '0;
      end else begin
         case (state)
            WR_IDLE: begin
               if (accept) begin
                  state <= WR_WRITE;
                  slot  <= '0;
                  // Bit 7 clear marks a new frame
                  if (!i_byte.data[7]) begin
                     addr <= '0;
                  end
               end
            end
            WR_WRITE: begin
               addr <= (addr == ADDR_LAST) ? '0 : addr + 1'b1;
               if (slot == 2'd2) begin
                  state <= WR_RELEASE;
               end else begin
                  slot <= slot + 1'b1;
               end
            end
            default: begin
               // Wait for the handshake to close
               if (!o_ack) begin
                  state <= WR_IDLE;
               end
            end
         endcase
      end
   end

   // Pixel fields only, bits 7:6 are not stored
   always_ff @(posedge i_clk) begin
      if (accept) begin
         pix_bits <= i_byte.data[5:0];
      end
   end

   always_comb begin
      o_wr.en   = (state == WR_WRITE);
      o_wr.addr = addr;
      case (slot)
         2'd0:    o_wr.data = pix_bits[1:0];
         2'd1:    o_wr.data = pix_bits[3:2];
         default: o_wr.data = pix_bits[5:4];
      endcase
   end

endmodule

//--- design/video_timing.sv
`timescale 1ns/100ps
`include "fb_params.svh"

module video_timing import fb_pkg::*; (
   input  logic      i_clk,
   input  logic      i_nrst,
   output scan_pos_t o_pos,
   output logic      o_hs,
   output logic      o_vs,
   output logic      o_de
);

   localparam int HW = `H_CNT_W;
   localparam int VW = `V_CNT_W;

   localparam logic [HW-1:0] H_LAST = HW'(`H_TOTAL - 1);
   localparam logic [HW-1:0] H_ACT  = HW'(`FB_W);
   localparam logic [HW-1:0] HS_BEG = HW'(`H_SYNC_START);
   localparam logic [HW-1:0] HS_END = HW'(`H_SYNC_START + `H_SYNC_LEN);

   localparam logic [VW-1:0] V_LAST = VW'(`V_TOTAL - 1);
   localparam logic [VW-1:0] V_ACT  = VW'(`FB_H);
   localparam logic [VW-1:0] VS_BEG = VW'(`V_SYNC_START);
   localparam logic [VW-1:0] VS_END = VW'(`V_SYNC_START + `V_SYNC_LEN);

   logic [HW-1:0] h_cnt;
   logic [VW-1:0] v_cnt;
   logic          h_act;
   logic          v_act;
   logic          hs_n;
   logic          vs_n;

   ////////////////////////////////////////////////////////////
   // Scan counters

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_cnt == H_LAST) begin
         h_cnt <= '0;
         v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   assign h_act = (h_cnt < H_ACT);
   assign v_act = (v_cnt < V_ACT);

   // Sync pulses sit in blanking, active low
   assign hs_n = !((h_cnt >= HS_BEG) && (h_cnt < HS_END));
   assign vs_n = !((v_cnt >= VS_BEG) && (v_cnt < VS_END));

   always_comb begin
      o_pos.x      = h_cnt[`FB_X_W-1:0];
      o_pos.y      = v_cnt[`FB_Y_W-1:0];
      o_pos.active = h_act && v_act;
   end

   ////////////////////////////////////////////////////////////
   // Outputs one clock behind the read position

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_hs <= 1'b1;
         o_vs <= 1'b1;
         o_de <= 1'b0;
      end else begin
         o_hs <= hs_n;
         o_vs <= vs_n;
         o_de <= o_pos.active;
      end
   end

endmodule

//--- design/frame_store.sv
`timescale 1ns/100ps
`include "fb_params.svh"

module frame_store import fb_pkg::*; (
   input  logic      i_clk,
   input  wr_port_t  i_wr,
   input  scan_pos_t i_pos,
   output pixel_t    o_pix
);

   localparam int ADDR_W = `FB_ADDR_W;

   pixel_t            mem [0:`FB_PIXELS-1];
   logic [ADDR_W-1:0] rd_addr;

   // Power-up picture is black
   initial begin
      for (int i = 0; i < `FB_PIXELS; i++) begin
         mem[i] = '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Write port

   always_ff @(posedge i_clk) begin
      if (i_wr.en) begin
         mem[i_wr.addr] <= i_wr.data;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read port

   // Row stride is a power of two, so y * FB_W is a shift
   assign rd_addr = (ADDR_W'(i_pos.y) << `FB_X_W) + ADDR_W'(i_pos.x);

   // Blank outside the active area
   always_ff @(posedge i_clk) begin
      if (i_pos.active) begin
         o_pix <= mem[rd_addr];
      end else begin
         o_pix <= '0;
      end
   end

endmodule

//--- design/fb_top.sv
`timescale 1ns/100ps

module fb_top import fb_pkg::*; (
   input  logic   i_clk,
   input  logic   i_nrst,
   input  logic   i_rx,
   output logic   o_hs,
   output logic   o_vs,
   output logic   o_de,
   output pixel_t o_r,
   output pixel_t o_g,
   output pixel_t o_b
);

   rx_byte_t   rx_byte;
   logic       req;
   logic       ack;
   wr_port_t   wr;
   scan_pos_t  pos;
   pixel_t     pix;
   logic       hs;
   logic       vs;
   logic       de;
   video_out_t vout;

   ////////////////////////////////////////////////////////////
   // Byte path

   uart_rx u_rx (
      .i_clk   (i_clk   ),
      .i_nrst  (i_nrst  ),
      .i_rx    (i_rx    ),
      .o_req   (req     ),
      .i_ack   (ack     ),
      .o_byte  (rx_byte )
   );

   pixel_writer u_writer (
      .i_clk   (i_clk   ),
      .i_nrst  (i_nrst  ),
      .i_req   (req     ),
      .o_ack   (ack     ),
      .i_byte  (rx_byte ),
      .o_wr    (wr      )
   );

   ////////////////////////////////////////////////////////////
   // Video path

   video_timing u_timing (
      .i_clk   (i_clk   ),
      .i_nrst  (i_nrst  ),
      .o_pos   (pos     ),
      .o_hs    (hs      ),
      .o_vs    (vs      ),
      .o_de    (de      )
   );

   frame_store u_store (
      .i_clk   (i_clk   ),
      .i_wr    (wr      ),
      .i_pos   (pos     ),
      .o_pix   (pix     )
   );

   // Gray palette
   assign vout.hs = hs;
   assign vout.vs = vs;
   assign vout.de = de;
   assign vout.r  = pix;
   assign vout.g  = pix;
   assign vout.b  = pix;

   assign o_hs = vout.hs;
   assign o_vs = vout.vs;
   assign o_de = vout.de;
   assign o_r  = vout.r;
   assign o_g  = vout.g;
   assign o_b  = vout.b;

endmodule

//--- test/fb_chk.sv
`timescale 1ns/100ps
`include "fb_params.svh"

module fb_chk import fb_pkg::*; (
   input logic     i_clk,
   input logic     i_nrst,
   input logic     i_req,
   input logic     i_ack,
   input wr_port_t i_wr,
   input logic     i_de,
   input logic     i_hs
);

   ////////////////////////////////////////////////////////////
   // Byte handshake

   a_ack_rise: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $rose(i_ack) |-> i_req)
      else $error("ack rose while req was low");

   a_req_fall: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $fell(i_req) |-> i_ack)
      else $error("req dropped before ack");

   // New byte only after the previous handshake closed
   a_req_rise: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $rose(i_req) |-> !i_ack)
      else $error("req rose while ack was still high");

   ////////////////////////////////////////////////////////////
   // Write port and video

   a_wr_addr: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_wr.en |-> (i_wr.addr < `FB_ADDR_W'(`FB_PIXELS)))
      else $error("write address %0d outside the frame", i_wr.addr);

   // Sync is active low
   a_de_hs: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !(i_de && !i_hs))
      else $error("data enable during horizontal sync");

endmodule

//--- test/fb_tb.sv
`timescale 1ns/100ps
`include "fb_params.svh"

module fb_tb;

   localparam int WAIT_LIMIT = 2 * `H_TOTAL * `V_TOTAL;

   logic              i_clk;
   logic              i_nrst;
   logic              i_rx;
   logic              o_hs;
   logic              o_vs;
   logic              o_de;
   logic [`PIX_W-1:0] o_r;
   logic [`PIX_W-1:0] o_g;
   logic [`PIX_W-1:0] o_b;

   logic [`PIX_W-1:0] exp_pix [0:`FB_PIXELS-1];
   logic [8*32-1:0]   test_name;
   int                n_tests;
   int                n_failed;
   int                n_errors;
   int                test_errors;

   fb_top dut (
      .i_clk  (i_clk  ),
      .i_nrst (i_nrst ),
      .i_rx   (i_rx   ),
      .o_hs   (o_hs   ),
      .o_vs   (o_vs   ),
      .o_de   (o_de   ),
      .o_r    (o_r    ),
      .o_g    (o_g    ),
      .o_b    (o_b    )
   );

   bind pixel_writer fb_chk u_wr_chk (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_req(i_req), .i_ack(o_ack),
      .i_wr(o_wr), .i_de(1'b0), .i_hs(1'b1)
   );

   bind video_timing fb_chk u_vt_chk (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_req(1'b0), .i_ack(1'b0),
      .i_wr('0), .i_de(o_de), .i_hs(o_hs)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   ////////////////////////////////////////////////////////////
   // Helpers

   // Start bit, 8 data bits LSB first, stop bit, then two idle bits
   task automatic send_byte(input logic [7:0] data);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         i_rx = frame[i];
         repeat (`CLKS_PER_BIT) @(negedge i_clk);
      end
      repeat (2 * `CLKS_PER_BIT) @(negedge i_clk);
   endtask

   task automatic check_idle();
      if (o_hs !== 1'b1 || o_vs !== 1'b1 || o_de !== 1'b0) begin
         $display("[ERROR] %0s: expected hs/vs/de 1/1/0 actual %b/%b/%b",
                  test_name, o_hs, o_vs, o_de);
         test_errors++;
      end
      if ({o_r, o_g, o_b} !== '0) begin
         $display("[ERROR] %0s: expected rgb 0 actual %0d %0d %0d",
                  test_name, o_r, o_g, o_b);
         test_errors++;
      end
   endtask

   task automatic capture_frame();
      int   guard;
      int   cnt;
      int   run;
      int   lines;
      int   clk_n;
      int   last_fall;
      logic prev_vs;
      logic prev_hs;
      logic prev_de;
      logic done;
      guard   = 0;
      prev_vs = 1'b1;
      @(negedge i_clk);
      // Frame starts where vertical sync ends
      while (!(o_vs && !prev_vs) && guard < WAIT_LIMIT) begin
         prev_vs = o_vs;
         @(negedge i_clk);
         guard++;
      end
      if (guard >= WAIT_LIMIT) begin
         $display("%0s: timed out waiting for vertical sync to end", test_name);
         test_errors++;
      end else begin
         cnt       = 0;
         run       = 0;
         lines     = 0;
         clk_n     = 0;
         last_fall = -1;
         prev_vs   = 1'b1;
         prev_hs   = o_hs;
         prev_de   = 1'b0;
         done      = 1'b0;
         while (!done && clk_n < WAIT_LIMIT) begin
            if (o_de) begin
               if (cnt < `FB_PIXELS) begin
                  if ({o_r, o_g, o_b} !== {3{exp_pix[cnt]}}) begin
                     $display("[ERROR] %0s pixel %0d rgb: expected %0d actual %0d %0d %0d",
                              test_name, cnt, exp_pix[cnt], o_r, o_g, o_b);
                     test_errors++;
                  end
               end
               cnt++;
               run++;
            end else begin
               // Blanking is black
               if ({o_r, o_g, o_b} !== '0) begin
                  $display("[ERROR] %0s blanking rgb: expected 0 actual %0d %0d %0d",
                           test_name, o_r, o_g, o_b);
                  test_errors++;
               end
               if (prev_de) begin
                  lines++;
                  if (run != `FB_W) begin
                     $display("[ERROR] %0s de run: expected %0d actual %0d",
                              test_name, `FB_W, run);
                     test_errors++;
                  end
                  run = 0;
               end
            end
            if (prev_hs && !o_hs) begin
               if (last_fall >= 0 && clk_n - last_fall != `H_TOTAL) begin
                  $display("[ERROR] %0s hsync period: expected %0d actual %0d",
                           test_name, `H_TOTAL, clk_n - last_fall);
                  test_errors++;
               end
               last_fall = clk_n;
            end
            done    = prev_vs && !o_vs;
            prev_vs = o_vs;
            prev_hs = o_hs;
            prev_de = o_de;
            @(negedge i_clk);
            clk_n++;
         end
         if (!done) begin
            $display("%0s: timed out waiting for the next vertical sync", test_name);
            test_errors++;
         end
         if (lines != `FB_H || cnt != `FB_PIXELS) begin
            $display("[ERROR] %0s lines/pixels: expected %0d/%0d actual %0d/%0d",
                     test_name, `FB_H, `FB_PIXELS, lines, cnt);
            test_errors++;
         end
      end
   endtask

   task automatic finish_test();
      n_tests++;
      if (test_errors == 0) begin
         $display("test %0s: ok", test_name);
      end else begin
         $display("test %0s: fail, %0d errors", test_name, test_errors);
         n_failed++;
      end
      n_errors    = n_errors + test_errors;
      test_errors = 0;
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      int                fd;
      int                code;
      int                idx;
      int                count;
      logic [7:0]        kind;
      logic [7:0]        data;
      logic [`PIX_W-1:0] val;
      logic [8*80-1:0]   line;
      i_rx        = 1'b1;
      i_nrst      = 1'b0;
      n_tests     = 0;
      n_failed    = 0;
      n_errors    = 0;
      test_errors = 0;
      test_name   = "reset_values";
      repeat (5) @(negedge i_clk);
      check_idle();
      repeat (5) @(negedge i_clk);
      check_idle();
      i_nrst = 1'b1;
      finish_test();

      fd = $fopen("test/fb_golden.txt", "r");
      if (fd == 0) begin
         $display("could not open test/fb_golden.txt");
         n_errors++;
      end else begin
         while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
               "#": code = $fgets(line, fd);
               "T": code = $fscanf(fd, "%s", test_name);
               "B": begin
                  code = $fscanf(fd, "%h %d", data, count);
                  if (code != 2) begin
                     $display("malformed byte line in the golden file");
                     n_errors++;
                  end else begin
                     repeat (count) send_byte(data);
                  end
               end
               // Value holds from idx to the end of the frame
               "P": begin
                  code = $fscanf(fd, "%d %d", idx, val);
                  if (code != 2) begin
                     $display("malformed pixel line in the golden file");
                     n_errors++;
                  end else begin
                     for (int i = idx; i < `FB_PIXELS; i++) begin
                        exp_pix[i] = val;
                     end
                  end
               end
               "E": begin
                  capture_frame();
                  finish_test();
               end
               default: begin
                  $display("unknown line type in the golden file: %c", kind);
                  n_errors++;
               end
            endcase
         end
         $fclose(fd);
      end

      $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
      if (n_failed == 0 && n_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- test/fb_golden.txt
# T name | B hex_byte repeat_count | E capture frame and compare
# P first_index pixel, the value holds up to the last pixel of the frame
T reset
P 0 0
E
T full_frame
B 24 1
B 95 31
B aa 32
P 0 0
P 1 1
P 2 2
P 3 1
P 96 2
E
T wrap
B b9 1
P 0 1
P 1 2
P 2 3
P 3 1
P 96 2
E
T restart
B 12 1
P 0 2
P 1 0
P 2 1
P 3 1
P 96 2
E
T ignored_bit6
B 3f 1
B 52 1
P 0 2
P 1 0
P 2 1
P 3 1
P 96 2
E

//--- sources.f
+incdir+include
design/fb_pkg.sv
design/uart_rx.sv
design/pixel_writer.sv
design/video_timing.sv
design/frame_store.sv
design/fb_top.sv
test/fb_chk.sv
test/fb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fb_tb -f sources.f -o fb_sim || exit 1
out=$(./obj_dir/fb_sim)
echo "$out"
echo "$out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
